/* compile.f */
common/serdes_rx_pkg.sv
rtl/rx_bit_delay.sv
deserializer/rx_deserializer.sv
deserializer/rx_word_aligner.sv
rtl/rx_lock_gate.sv
rtl/rx_csr_axil.sv
rtl/serdes_rx_top.sv
verif/tb_serdes_rx.sv

/* Bender.yml */
package:
  name: serdes_rx

sources:
  - common/serdes_rx_pkg.sv
  - rtl/rx_bit_delay.sv
  - deserializer/rx_deserializer.sv
  - deserializer/rx_word_aligner.sv
  - rtl/rx_lock_gate.sv
  - rtl/rx_csr_axil.sv
  - rtl/serdes_rx_top.sv
  - target: test
    files:
      - verif/tb_serdes_rx.sv

/* verif/tb_serdes_rx.sv */
// Receive lane testbench
// Directed tests for reset, registers, alignment, capture, bitslip and enable gating
module tb_serdes_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int               WIDTH          = 10;       // DUT default
    localparam int               TAPS           = 2;        // Tap setting from test 3 on
    localparam int               TIMEOUT_CYCLES = 2000 * 6; // Six tests
    localparam logic [WIDTH-1:0] TRAIN_PAT      = 10'h0F3;

    logic             clkGHz_clkbuf;
    logic             reset_buf_n;
    logic             data_i;
    logic [WIDTH-1:0] data_o;
    logic             data_valid;
    logic             ready;
    logic [3:0]       awaddr;
    logic             awvalid;
    logic             awready;
    logic [31:0]      wdata;
    logic [3:0]       wstrb;
    logic             wvalid;
    logic             wready;
    logic [1:0]       bresp;
    logic             bvalid;
    logic             bready;
    logic [3:0]       araddr;
    logic             arvalid;
    logic             arready;
    logic [31:0]      rdata;
    logic [1:0]       rresp;
    logic             rvalid;
    logic             rready;

    int               cycle_count   = 0;
    int               error_count   = 0;
    int               check_count   = 0;
    int               words_checked = 0;
    int               start_offset  = 0;       // Bits skipped at the next word
    integer           seed          = 7;
    logic [WIDTH-1:0] fill_word     = '0;      // Sent when no test word waits
    logic [WIDTH-1:0] tx_queue[$];
    logic [WIDTH-1:0] exp_queue[$];
    int               due_queue[$];            // Earliest output cycle per word

    serdes_rx_top serdes_rx_top_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .data_i        (data_i),
        .data_o        (data_o),
        .data_valid    (data_valid),
        .ready         (ready),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready)
    );

    initial clkGHz_clkbuf = 1'b0;
    always #50 clkGHz_clkbuf = ~clkGHz_clkbuf; // 100 ns period

    always @(posedge clkGHz_clkbuf) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) @(posedge clkGHz_clkbuf);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_word(input logic [WIDTH-1:0] actual, input logic [WIDTH-1:0] expected,
                              input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL @%0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_reg(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL @%0t: %s got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_resp(input logic [1:0] actual, input logic [1:0] expected,
                              input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL @%0t: %s got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL @%0t: %s got %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // slip_count may lie anywhere from the expected value up to slip_span above it
    task automatic check_status(input serdes_rx_pkg::rx_status_t actual,
                                input serdes_rx_pkg::rx_status_t expected,
                                input int slip_span, input string what);
        check_count++;
        if (actual.dpa_lock !== expected.dpa_lock || actual.ready !== expected.ready) begin
            error_count++;
            $display("FAIL @%0t: %s lock/ready got %b%b, expected %b%b", $time, what,
                     actual.dpa_lock, actual.ready, expected.dpa_lock, expected.ready);
        end
        if (actual.slip_count < expected.slip_count ||
            actual.slip_count > expected.slip_count + slip_span) begin
            error_count++;
            $display("FAIL @%0t: %s slip_count %0d outside %0d to %0d", $time, what,
                     actual.slip_count, expected.slip_count, expected.slip_count + slip_span);
        end
    endtask

    function automatic logic [31:0] ctrl_word(input logic enable, input logic align_en,
                                              input logic [2:0] taps);
        logic [31:0] r;
        r      = '0;
        r[0]   = enable;
        r[1]   = align_en;
        r[6:4] = taps;
        return r;
    endfunction

    function automatic serdes_rx_pkg::rx_status_t status_from_reg(input logic [31:0] r);
        serdes_rx_pkg::rx_status_t s;
        s.dpa_lock   = r[0];
        s.ready      = r[1];
        s.slip_count = r[15:8];
        return s;
    endfunction

    // ******************************
    // Bus and serial drivers
    // ******************************
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clkGHz_clkbuf);
        #5;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        @(negedge clkGHz_clkbuf);
        while (!awready) @(negedge clkGHz_clkbuf);
        check_flag(wready, 1'b1, "wready with awready");
        @(posedge clkGHz_clkbuf); // Address and data taken here
        #5;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clkGHz_clkbuf);
        while (!bvalid) @(negedge clkGHz_clkbuf);
        check_resp(bresp, 2'b00, "write response");
        @(posedge clkGHz_clkbuf);
        #5;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clkGHz_clkbuf);
        #5;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clkGHz_clkbuf);
        while (!arready) @(negedge clkGHz_clkbuf);
        @(posedge clkGHz_clkbuf);
        #5;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clkGHz_clkbuf);
        while (!rvalid) @(negedge clkGHz_clkbuf);
        data = rdata;
        check_resp(rresp, 2'b00, "read response");
        @(posedge clkGHz_clkbuf);
        #5;
        rready = 1'b0;
    endtask

    // One word MSB first, the first offset bits left out
    task automatic send_word(input logic [WIDTH-1:0] word, input int offset, input bit track);
        for (int i = WIDTH - 1 - offset; i >= 0; i--) begin
            @(posedge clkGHz_clkbuf);
            #5;
            data_i = word[i];
            if (track && i == WIDTH - 1) begin
                exp_queue.push_back(word);
                due_queue.push_back(cycle_count + TAPS + WIDTH + 2); // First bit to data_o
            end
        end
    endtask

    initial begin : serial_source
        logic [WIDTH-1:0] word;
        int               offset;
        bit               track;
        @(posedge reset_buf_n);
        forever begin
            track = (tx_queue.size() > 0);
            if (track) begin
                word = tx_queue.pop_front();
            end else begin
                word = fill_word;
            end
            offset       = start_offset;
            start_offset = 0;
            send_word(word, offset, track);
        end
    end

    // Test words are compared in order; filler words ahead of them are skipped
    always @(negedge clkGHz_clkbuf) begin : scoreboard
        logic [WIDTH-1:0] expected;
        if (data_valid && exp_queue.size() > 0 && cycle_count >= due_queue[0]) begin
            expected = exp_queue.pop_front();
            due_queue.delete(0);
            check_word(data_o, expected, "captured word");
            words_checked++;
        end
    end

    task automatic next_word(output logic [WIDTH-1:0] word);
        @(negedge clkGHz_clkbuf);
        while (!data_valid) @(negedge clkGHz_clkbuf);
        word = data_o;
    endtask

    // ******************************
    // Directed tests
    // ******************************
    task automatic test_reset_state();
        logic [31:0] rd;
        check_flag(data_valid, 1'b0, "data_valid after reset");
        check_flag(ready, 1'b0, "ready after reset");
        axil_read(serdes_rx_pkg::REG_CTRL, rd);
        check_reg(rd, ctrl_word(1'b0, 1'b1, 3'd0), "CTRL reset value");
        axil_read(serdes_rx_pkg::REG_PATTERN, rd);
        check_reg(rd, 32'h0000_00F3, "PATTERN reset value");
        axil_read(serdes_rx_pkg::REG_STATUS, rd);
        check_status(status_from_reg(rd), '0, 0, "STATUS after reset");
    endtask

    task automatic test_register_access();
        logic [31:0] rd;
        axil_write(serdes_rx_pkg::REG_CTRL, 32'h0000_00D2);    // Bit 7 is not stored
        axil_write(serdes_rx_pkg::REG_PATTERN, 32'hFFFF_F2A5); // Only 10 bits kept
        axil_read(serdes_rx_pkg::REG_CTRL, rd);
        check_reg(rd, ctrl_word(1'b0, 1'b1, 3'd5), "CTRL readback");
        axil_read(serdes_rx_pkg::REG_PATTERN, rd);
        check_reg(rd, 32'h0000_02A5, "PATTERN readback");
        axil_write(serdes_rx_pkg::REG_STATUS, 32'hFFFF_FFFF);
        axil_read(serdes_rx_pkg::REG_STATUS, rd);
        check_reg(rd, 32'h0, "STATUS after write");
    endtask

    task automatic test_auto_align();
        logic [31:0]               rd;
        serdes_rx_pkg::rx_status_t expected;
        fill_word    = TRAIN_PAT;
        start_offset = 3;
        axil_write(serdes_rx_pkg::REG_PATTERN, 32'(TRAIN_PAT));
        axil_write(serdes_rx_pkg::REG_CTRL, ctrl_word(1'b1, 1'b1, 3'(TAPS)));
        rd = '0;
        while (rd[1:0] != 2'b11) axil_read(serdes_rx_pkg::REG_STATUS, rd); // Poll for lock
        expected.dpa_lock   = 1'b1;
        expected.ready      = 1'b1;
        expected.slip_count = 8'd1;
        check_status(status_from_reg(rd), expected, WIDTH - 1, "STATUS after alignment");
        check_flag(ready, 1'b1, "ready after alignment");
    endtask

    task automatic test_data_capture();
        logic [WIDTH-1:0] word;
        axil_write(serdes_rx_pkg::REG_CTRL, ctrl_word(1'b1, 1'b0, 3'(TAPS)));
        check_flag(ready, 1'b1, "ready with align_en low");
        words_checked = 0;
        for (int i = 0; i < 20; i++) begin
            word = $random(seed);
            tx_queue.push_back(word);
        end
        while (words_checked < 20) @(negedge clkGHz_clkbuf);
    endtask

    task automatic test_manual_slip();
        logic [WIDTH-1:0] word;
        logic [WIDTH-1:0] rotated;
        rotated = {TRAIN_PAT[WIDTH-2:0], TRAIN_PAT[WIDTH-1]};
        axil_write(serdes_rx_pkg::REG_SLIP, 32'h1);
        next_word(word); // Word in flight across the slip
        repeat (4) begin
            next_word(word);
            check_word(word, rotated, "word after manual bitslip");
        end
    endtask

    task automatic test_enable_gating();
        logic [WIDTH-1:0] word;
        axil_write(serdes_rx_pkg::REG_CTRL, ctrl_word(1'b0, 1'b0, 3'(TAPS)));
        repeat (2) next_word(word); // Still hold bits from before enable fell
        repeat (4) begin
            next_word(word);
            check_word(word, '0, "word with enable low");
        end
    endtask

    initial begin : main
        reset_buf_n = 1'b0;
        data_i      = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        repeat (10) @(posedge clkGHz_clkbuf);
        #5;
        reset_buf_n = 1'b1;
        test_reset_state();
        test_register_access();
        test_auto_align();
        test_data_capture();
        test_manual_slip();
        test_enable_gating();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* rtl/serdes_rx_top.sv */
// Source-synchronous receive lane
// Delay, deserializer, word aligner and lock gate, configured over AXI4-Lite
module serdes_rx_top #(
    parameter int WIDTH         = 10,
    parameter int LOCK_WORDS    = 4,
    parameter int SETTLE_CYCLES = 255
) (
    input  logic             clkGHz_clkbuf,
    input  logic             reset_buf_n,
    input  logic             data_i,
    output logic [WIDTH-1:0] data_o,
    output logic             data_valid,
    output logic             ready,
    input  logic [3:0]       awaddr,
    input  logic             awvalid,
    output logic             awready,
    input  logic [31:0]      wdata,
    input  logic [3:0]       wstrb,
    input  logic             wvalid,
    output logic             wready,
    output logic [1:0]       bresp,
    output logic             bvalid,
    input  logic             bready,
    input  logic [3:0]       araddr,
    input  logic             arvalid,
    output logic             arready,
    output logic [31:0]      rdata,
    output logic [1:0]       rresp,
    output logic             rvalid,
    input  logic             rready
);

    serdes_rx_pkg::rx_cfg_t    cfg;
    serdes_rx_pkg::rx_word_t   word_raw;
    serdes_rx_pkg::rx_status_t status;
    logic                      slip_req_csr;
    logic                      slip_req;
    logic                      bitslip;
    logic                      bit_d;
    logic                      dpa_lock;
    logic [7:0]                slip_count;

    assign bitslip = slip_req | slip_req_csr; // Aligner or manual

    rx_csr_axil csr_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .status        (status),
        .cfg           (cfg),
        .slip_req_csr  (slip_req_csr)
    );

    rx_bit_delay bit_delay_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .data_i        (data_i),
        .cfg           (cfg),
        .bit_d         (bit_d)
    );

    rx_deserializer #(.WIDTH(WIDTH)) deser_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .bit_d         (bit_d),
        .bitslip       (bitslip),
        .word_raw      (word_raw)
    );

    rx_word_aligner #(
        .WIDTH      (WIDTH),
        .LOCK_WORDS (LOCK_WORDS)
    ) aligner_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word_raw      (word_raw),
        .cfg           (cfg),
        .slip_req      (slip_req),
        .dpa_lock      (dpa_lock),
        .slip_count    (slip_count)
    );

    rx_lock_gate #(
        .WIDTH         (WIDTH),
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) lock_gate_inst (
        .clkGHz_clkbuf (clkGHz_clkbuf),
        .reset_buf_n   (reset_buf_n),
        .word_raw      (word_raw),
        .dpa_lock      (dpa_lock),
        .slip_count    (slip_count),
        .cfg           (cfg),
        .data_o        (data_o),
        .data_valid    (data_valid),
        .ready         (ready),
        .status        (status)
    );

endmodule

/* rtl/rx_csr_axil.sv */
// AXI4-Lite register block
// Control, training pattern, status and manual bitslip registers
module rx_csr_axil (
    input  logic                      clkGHz_clkbuf,
    input  logic                      reset_buf_n,
    input  logic [3:0]                awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [3:0]                araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  serdes_rx_pkg::rx_status_t status,
    output serdes_rx_pkg::rx_cfg_t    cfg,
    output logic                      slip_req_csr
);

    localparam int PAT_MSB = serdes_rx_pkg::WIDTH_MAX - 1;

    logic        aw_hs;
    logic        ar_hs;
    logic [31:0] rd_word;

    assign aw_hs = awvalid & wvalid & awready; // Address and data together
    assign ar_hs = arvalid & arready;
    assign wready = awready;
    assign bresp  = 2'b00; // Always OKAY
    assign rresp  = 2'b00;

    // ******************************
    // Write channel
    // ******************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            awready      <= 1'b0;
            bvalid       <= 1'b0;
            cfg          <= serdes_rx_pkg::CFG_RESET;
            slip_req_csr <= 1'b0;
        end else begin
            awready      <= awvalid & wvalid & ~awready & ~bvalid;
            slip_req_csr <= 1'b0;
            if (aw_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (aw_hs) begin
                case (awaddr)
                    serdes_rx_pkg::REG_CTRL: begin
                        if (wstrb[0]) begin
                            cfg.enable     <= wdata[0];
                            cfg.align_en   <= wdata[1];
                            cfg.delay_taps <= wdata[6:4];
                        end
                    end
                    serdes_rx_pkg::REG_PATTERN: begin
                        if (wstrb[0]) cfg.train_pattern[7:0] <= wdata[7:0];
                        if (wstrb[1]) cfg.train_pattern[PAT_MSB:8] <= wdata[PAT_MSB:8];
                    end
                    serdes_rx_pkg::REG_SLIP: slip_req_csr <= 1'b1; // One-cycle pulse
                    default: ;
                endcase
            end
        end
    end

    // ******************************
    // Read channel
    // ******************************
    always_comb begin
        case (araddr)
            serdes_rx_pkg::REG_CTRL:
                rd_word = {25'd0, cfg.delay_taps, 2'b00, cfg.align_en, cfg.enable};
            serdes_rx_pkg::REG_PATTERN:
                rd_word = 32'(cfg.train_pattern);
            serdes_rx_pkg::REG_STATUS:
                rd_word = {16'd0, status.slip_count, 6'd0, status.ready, status.dpa_lock};
            default:
                rd_word = '0; // Unmapped
        endcase
    end

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid & ~arready & ~rvalid;
            if (ar_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (ar_hs) begin
            rdata <= rd_word;
        end
    end

endmodule

/* rtl/rx_lock_gate.sv */
// Lock gate
// Waits out the settling count, decides ready and registers each
// aligned word while the lane is ready
module rx_lock_gate #(
    parameter int WIDTH         = 10,
    parameter int SETTLE_CYCLES = 255
) (
    input  logic                      clkGHz_clkbuf,
    input  logic                      reset_buf_n,
    input  serdes_rx_pkg::rx_word_t   word_raw,
    input  logic                      dpa_lock,
    input  logic [7:0]                slip_count,
    input  serdes_rx_pkg::rx_cfg_t    cfg,
    output logic [WIDTH-1:0]          data_o,
    output logic                      data_valid,
    output logic                      ready,
    output serdes_rx_pkg::rx_status_t status
);

    localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);

    logic [CNT_W-1:0] settle_q;
    logic             settled;

    assign settled = (settle_q == CNT_W'(SETTLE_CYCLES)); // Stands in for PLL lock
    assign ready   = settled & (dpa_lock | ~cfg.align_en);

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_q   <= '0;
            data_valid <= 1'b0;
        end else begin
            if (!settled) begin
                settle_q <= settle_q + 1'b1;
            end
            data_valid <= word_raw.valid & ready;
        end
    end

    always_ff @(posedge clkGHz_clkbuf) begin
        if (word_raw.valid && ready) begin
            data_o <= word_raw.data[WIDTH-1:0];
        end
    end

    assign status.dpa_lock   = dpa_lock;
    assign status.ready      = ready;
    assign status.slip_count = slip_count;

endmodule

/* deserializer/rx_word_aligner.sv */
// Word aligner
// Compares each completed word with the training pattern and slips
// the deserializer until LOCK_WORDS words in a row match
module rx_word_aligner #(
    parameter int WIDTH      = 10,
    parameter int LOCK_WORDS = 4
) (
    input  logic                    clkGHz_clkbuf,
    input  logic                    reset_buf_n,
    input  serdes_rx_pkg::rx_word_t word_raw,
    input  serdes_rx_pkg::rx_cfg_t  cfg,
    output logic                    slip_req,
    output logic                    dpa_lock,
    output logic [7:0]              slip_count
);

    localparam int MATCH_W = $clog2(LOCK_WORDS + 1);

    typedef enum logic [1:0] {
        HUNT,
        SETTLE,
        LOCKED
    } align_state_t;

    align_state_t     state_q;
    logic [MATCH_W-1:0] match_cnt_q;
    logic             settle_cnt_q; // Counts the two ignored words
    logic             active;
    logic             match;

    // Hunting on a disabled lane would only count slips on zeros
    assign active = cfg.align_en & cfg.enable;
    assign match  = (word_raw.data[WIDTH-1:0] == cfg.train_pattern[WIDTH-1:0]);

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state_q      <= HUNT;
            match_cnt_q  <= '0;
            settle_cnt_q <= 1'b0;
            slip_req     <= 1'b0;
            slip_count   <= '0;
        end else if (!active) begin
            state_q     <= HUNT; // Lock drops with align_en
            match_cnt_q <= '0;
            slip_req    <= 1'b0;
        end else begin
            slip_req <= 1'b0;
            if (word_raw.valid) begin
                if (state_q == SETTLE) begin
                    settle_cnt_q <= ~settle_cnt_q;
                    if (settle_cnt_q) begin
                        state_q <= HUNT; // Second word skipped
                    end
                end else if (!match) begin
                    // Mismatch in hunt or lock
                    state_q      <= SETTLE;
                    match_cnt_q  <= '0;
                    settle_cnt_q <= 1'b0;
                    slip_req     <= 1'b1;
                    if (slip_count != 8'hFF) begin
                        slip_count <= slip_count + 1'b1;
                    end
                end else if (state_q == HUNT) begin
                    match_cnt_q <= match_cnt_q + 1'b1;
                    if (match_cnt_q == MATCH_W'(LOCK_WORDS - 1)) begin
                        state_q <= LOCKED;
                    end
                end
            end
        end
    end

    assign dpa_lock = (state_q == LOCKED);

    a_no_slip_locked: assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        !(slip_req && dpa_lock)
    ) else $error("slip_req raised while locked");

endmodule

/* deserializer/rx_deserializer.sv */
// Deserializer with bitslip
// Shifts the delayed bit in MSB first and emits a word every WIDTH
// cycles. A bitslip holds the bit counter for one cycle, which moves
// every later word boundary one bit later.
module rx_deserializer #(
    parameter int WIDTH = 10
) (
    input  logic                    clkGHz_clkbuf,
    input  logic                    reset_buf_n,
    input  logic                    bit_d,
    input  logic                    bitslip,
    output serdes_rx_pkg::rx_word_t word_raw
);

    localparam int W_MAX = serdes_rx_pkg::WIDTH_MAX;
    localparam int CNT_W = $clog2(WIDTH);

    logic [WIDTH-2:0] shift_q; // Older bits of the word in progress
    logic [WIDTH-1:0] word_q;
    logic             valid_q;
    logic [CNT_W-1:0] bit_cnt_q;
    logic             last_bit;

    assign last_bit = (bit_cnt_q == CNT_W'(WIDTH - 1));

    // Shift line runs every cycle
    always_ff @(posedge clkGHz_clkbuf) begin
        shift_q <= {shift_q[WIDTH-3:0], bit_d};
        if (last_bit && !bitslip) begin
            word_q <= {shift_q, bit_d}; // Last bit enters as LSB
        end
    end

    // ******************************
    // Bit counter and word strobe
    // ******************************
    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (bitslip) begin
                bit_cnt_q <= bit_cnt_q; // Stall one bit
            end else if (last_bit) begin
                bit_cnt_q <= '0;
                valid_q   <= 1'b1;
            end else begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    assign word_raw.data  = W_MAX'(word_q); // Upper bits stay 0
    assign word_raw.valid = valid_q;

    if (WIDTH >= 2) begin : g_strobe_check
        a_valid_single: assert property (
            @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
            word_raw.valid |=> !word_raw.valid
        ) else $error("word_raw.valid held for two cycles");
    end

endmodule

/* rtl/rx_bit_delay.sv */
// Input delay stage
// Gates the serial bit with enable, then delays it by 1 to 8 cycles
module rx_bit_delay (
    input  logic                    clkGHz_clkbuf,
    input  logic                    reset_buf_n,
    input  logic                    data_i,
    input  serdes_rx_pkg::rx_cfg_t  cfg,
    output logic                    bit_d
);

    localparam int DEPTH = 2 ** serdes_rx_pkg::TAP_BITS;

    logic [DEPTH-1:0] line_q; // Tap 0 is the youngest bit
    logic             bit_gated;

    assign bit_gated = data_i & cfg.enable; // Disabled lane reads as 0

    always_ff @(posedge clkGHz_clkbuf or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            line_q <= '0;
        end else begin
            line_q <= {line_q[DEPTH-2:0], bit_gated};
        end
    end

    assign bit_d = line_q[cfg.delay_taps]; // Tap mux

    // A full line of disabled input leaves only zeros at any tap
    a_disabled_flush: assert property (
        @(posedge clkGHz_clkbuf) disable iff (!reset_buf_n)
        (!cfg.enable) [*DEPTH] |=> (bit_d == 1'b0)
    ) else $error("bit_d not zero after enable fell");

endmodule

/* common/serdes_rx_pkg.sv */
// Receive lane shared definitions
// Control, word and status structs, register map and reset defaults
package serdes_rx_pkg;

    localparam int WIDTH_MAX = 10; // Widest supported word
    localparam int TAP_BITS  = 3;  // Selects 0 to 7 taps

    // ******************************
    // Lane structs
    // ******************************
    typedef struct packed {
        logic                 enable;
        logic                 align_en;
        logic [TAP_BITS-1:0]  delay_taps;
        logic [WIDTH_MAX-1:0] train_pattern;
    } rx_cfg_t;

    // Narrow stages use the low bits of data
    typedef struct packed {
        logic [WIDTH_MAX-1:0] data;
        logic                 valid;
    } rx_word_t;

    typedef struct packed {
        logic       dpa_lock;
        logic       ready;
        logic [7:0] slip_count; // Saturates at 255
    } rx_status_t;

    // ******************************
    // Register map
    // ******************************
    localparam logic [3:0] REG_CTRL    = 4'h0; // enable, align_en, delay_taps
    localparam logic [3:0] REG_PATTERN = 4'h4; // Training pattern
    localparam logic [3:0] REG_STATUS  = 4'h8; // Read only
    localparam logic [3:0] REG_SLIP    = 4'hC; // Any write slips once

    localparam rx_cfg_t CFG_RESET = '{
        enable:        1'b0,
        align_en:      1'b1,
        delay_taps:    '0,
        train_pattern: 10'h0F3
    };

endpackage
